// File: Bender.yml
package:
  name: parser

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/parser_pkg.sv
      - rtl/queue_dispatch.sv
      - rtl/table_write_ctrl.sv
      - rtl/act_lookup.sv
      - rtl/parser_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/parser_chk.sv
      - test/parser_tb.sv

// File: parser.f
+incdir+rtl
rtl/parser_pkg.sv
rtl/queue_dispatch.sv
rtl/table_write_ctrl.sv
rtl/act_lookup.sv
rtl/parser_top.sv
test/parser_chk.sv
test/parser_tb.sv

// File: rtl/act_lookup.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module act_lookup
	import parser_pkg::*;
(
	input  logic       axis_clk,
	input  logic       aresetn,

	// table write port
	input  logic       tbl_wr_en,
	input  tbl_index_t tbl_wr_index,
	input  act_entry_t tbl_wr_entry,

	// lookup request
	input  vlan_id_t   s_vlan_id,
	input  logic       s_vlan_id_valid,
	input  logic       s_axis_tvalid,
	input  logic       s_axis_tlast,

	output logic       lookup_ready,
	output act_entry_t act_entry,
	output logic       act_valid
);

	localparam int ADDR_W = $clog2(`PARSER_TBL_DEPTH);
	localparam int VLAN_ADDR_LSB = 4;

	act_entry_t act_ram [`PARSER_TBL_DEPTH];
	act_entry_t rd_data;
	act_entry_t lookup_data;
	logic       busy;
	logic       rd_done;
	logic       valid_d1;

	// ========================================================================
	// parse-action RAM, read port follows the VLAN id every cycle
	// ========================================================================
	always_ff @(posedge axis_clk) begin
		if (tbl_wr_en) begin
			act_ram[tbl_wr_index[ADDR_W-1:0]] <= tbl_wr_entry;
		end
		rd_data <= act_ram[s_vlan_id[VLAN_ADDR_LSB +: ADDR_W]];
	end

	// ========================================================================
	// lookup sequencer
	// ========================================================================
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			busy <= 1'b0;
			rd_done <= 1'b0;
			valid_d1 <= 1'b0;
			act_valid <= 1'b0;
			lookup_ready <= 1'b1;
		end else begin
			rd_done <= 1'b0;
			valid_d1 <= rd_done;
			act_valid <= valid_d1;
			if (!busy) begin
				if (s_vlan_id_valid) begin
					busy <= 1'b1;
					// hold off the packet after a closing beat
					if (s_axis_tvalid && s_axis_tlast) begin
						lookup_ready <= 1'b0;
					end
				end
			end else begin
				busy <= 1'b0;
				rd_done <= 1'b1;
				lookup_ready <= 1'b1;
			end
		end
	end

	// keep the read result until the valid delay line catches up
	always_ff @(posedge axis_clk) begin
		if (busy) begin
			lookup_data <= rd_data;
		end
		if (valid_d1) begin
			act_entry <= lookup_data;
		end
	end

endmodule

// File: rtl/parser_pkg.sv
`include "parser_settings.svh"

package parser_pkg;

	// stream beat fields
	typedef logic [`PARSER_DATA_WIDTH-1:0] axis_data_t;
	typedef logic [`PARSER_TUSER_WIDTH-1:0] axis_tuser_t;
	typedef logic [`PARSER_DATA_WIDTH/8-1:0] axis_tkeep_t;

	// lookup key
	typedef logic [`PARSER_VLAN_WIDTH-1:0] vlan_id_t;

	// one parse-action entry, byte 0 of the control beat on top
	typedef logic [`PARSER_ENTRY_WIDTH-1:0] act_entry_t;

	// table index as carried in the control header byte
	typedef logic [7:0] tbl_index_t;

	// downstream queue number
	typedef logic [$clog2(`PARSER_NUM_QUEUES)-1:0] queue_sel_t;

	// control stream write sequence
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_WR_FIRST,
		CTRL_WR_MORE
	} ctrl_state_e;

endpackage

// File: rtl/parser_settings.svh
`ifndef PARSER_SETTINGS_SVH
`define PARSER_SETTINGS_SVH

// ============================================================================
// stream widths
// ============================================================================
`define PARSER_DATA_WIDTH   512
`define PARSER_TUSER_WIDTH  128
`define PARSER_VLAN_WIDTH   12

// parse-action table
`define PARSER_ENTRY_WIDTH  160
`define PARSER_TBL_DEPTH    32

// downstream packet queues
`define PARSER_NUM_QUEUES   4

// control packet matching
`define PARSER_MOD_ID       3'd0
`define PARSER_CTRL_FLAG    16'hf2f1

// bit offsets inside a control beat
`define PARSER_FLAG_LSB     320
`define PARSER_MODID_LSB    368
`define PARSER_INDEX_LSB    384

`endif

// File: rtl/parser_top.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module parser_top
	import parser_pkg::*;
(
	input  logic                          axis_clk,
	input  logic                          aresetn,

	// packet stream in
	input  axis_data_t                    s_axis_tdata,
	input  axis_tuser_t                   s_axis_tuser,
	input  axis_tkeep_t                   s_axis_tkeep,
	input  logic                          s_axis_tvalid,
	input  logic                          s_axis_tlast,
	output logic                          s_axis_tready,

	// shared queue bundle, per-queue handshake
	output axis_data_t                    m_axis_tdata,
	output axis_tuser_t                   m_axis_tuser,
	output axis_tkeep_t                   m_axis_tkeep,
	output logic                          m_axis_tlast,
	output logic [`PARSER_NUM_QUEUES-1:0] m_axis_tvalid,
	input  logic [`PARSER_NUM_QUEUES-1:0] m_axis_tready,

	// action lookup
	input  vlan_id_t                      s_vlan_id,
	input  logic                          s_vlan_id_valid,
	output act_entry_t                    act_entry,
	output logic                          act_valid,

	// control stream
	input  axis_data_t                    ctrl_s_axis_tdata,
	input  axis_tuser_t                   ctrl_s_axis_tuser,
	input  axis_tkeep_t                   ctrl_s_axis_tkeep,
	input  logic                          ctrl_s_axis_tvalid,
	input  logic                          ctrl_s_axis_tlast,
	output axis_data_t                    ctrl_m_axis_tdata,
	output axis_tuser_t                   ctrl_m_axis_tuser,
	output axis_tkeep_t                   ctrl_m_axis_tkeep,
	output logic                          ctrl_m_axis_tvalid,
	output logic                          ctrl_m_axis_tlast
);

	logic       lookup_ready;
	logic       tbl_wr_en;
	tbl_index_t tbl_wr_index;
	act_entry_t tbl_wr_entry;

	// all queues see the same beat
	assign m_axis_tdata = s_axis_tdata;
	assign m_axis_tuser = s_axis_tuser;
	assign m_axis_tkeep = s_axis_tkeep;
	assign m_axis_tlast = s_axis_tlast;

	queue_dispatch queue_dispatch_inst (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.m_axis_tready (m_axis_tready),
		.lookup_ready  (lookup_ready),
		.s_axis_tready (s_axis_tready),
		.m_axis_tvalid (m_axis_tvalid)
	);

	table_write_ctrl table_write_ctrl_inst (
		.axis_clk           (axis_clk),
		.aresetn            (aresetn),
		.ctrl_s_axis_tdata  (ctrl_s_axis_tdata),
		.ctrl_s_axis_tuser  (ctrl_s_axis_tuser),
		.ctrl_s_axis_tkeep  (ctrl_s_axis_tkeep),
		.ctrl_s_axis_tvalid (ctrl_s_axis_tvalid),
		.ctrl_s_axis_tlast  (ctrl_s_axis_tlast),
		.ctrl_m_axis_tdata  (ctrl_m_axis_tdata),
		.ctrl_m_axis_tuser  (ctrl_m_axis_tuser),
		.ctrl_m_axis_tkeep  (ctrl_m_axis_tkeep),
		.ctrl_m_axis_tvalid (ctrl_m_axis_tvalid),
		.ctrl_m_axis_tlast  (ctrl_m_axis_tlast),
		.tbl_wr_en          (tbl_wr_en),
		.tbl_wr_index       (tbl_wr_index),
		.tbl_wr_entry       (tbl_wr_entry)
	);

	act_lookup act_lookup_inst (
		.axis_clk        (axis_clk),
		.aresetn         (aresetn),
		.tbl_wr_en       (tbl_wr_en),
		.tbl_wr_index    (tbl_wr_index),
		.tbl_wr_entry    (tbl_wr_entry),
		.s_vlan_id       (s_vlan_id),
		.s_vlan_id_valid (s_vlan_id_valid),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tlast    (s_axis_tlast),
		.lookup_ready    (lookup_ready),
		.act_entry       (act_entry),
		.act_valid       (act_valid)
	);

endmodule

// File: rtl/queue_dispatch.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module queue_dispatch
	import parser_pkg::*;
(
	input  logic                          axis_clk,
	input  logic                          aresetn,
	input  logic                          s_axis_tvalid,
	input  logic                          s_axis_tlast,
	input  logic [`PARSER_NUM_QUEUES-1:0] m_axis_tready,
	input  logic                          lookup_ready,
	output logic                          s_axis_tready,
	output logic [`PARSER_NUM_QUEUES-1:0] m_axis_tvalid
);

	localparam queue_sel_t LAST_QUEUE = queue_sel_t'(`PARSER_NUM_QUEUES - 1);

	queue_sel_t cur_queue;
	queue_sel_t next_queue;
	logic       beat_xfer;

	// upstream only moves when every queue and the lookup can take it
	assign s_axis_tready = lookup_ready & (&m_axis_tready);
	assign beat_xfer = s_axis_tvalid & s_axis_tready;

	assign next_queue = (cur_queue == LAST_QUEUE) ? '0 : cur_queue + 1'b1;

	// valid steered to the current queue only
	for (genvar q = 0; q < `PARSER_NUM_QUEUES; q++) begin : g_valid
		assign m_axis_tvalid[q] = (cur_queue == queue_sel_t'(q))
			& s_axis_tvalid & m_axis_tready[q];
	end

	// ========================================================================
	// round-robin, one whole packet per queue
	// ========================================================================
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			cur_queue <= '0;
		end else if (beat_xfer && s_axis_tlast) begin
			// packet closed, the next one goes to the following queue
			cur_queue <= next_queue;
		end
	end

endmodule

// File: rtl/table_write_ctrl.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module table_write_ctrl
	import parser_pkg::*;
(
	input  logic        axis_clk,
	input  logic        aresetn,

	input  axis_data_t  ctrl_s_axis_tdata,
	input  axis_tuser_t ctrl_s_axis_tuser,
	input  axis_tkeep_t ctrl_s_axis_tkeep,
	input  logic        ctrl_s_axis_tvalid,
	input  logic        ctrl_s_axis_tlast,

	output axis_data_t  ctrl_m_axis_tdata,
	output axis_tuser_t ctrl_m_axis_tuser,
	output axis_tkeep_t ctrl_m_axis_tkeep,
	output logic        ctrl_m_axis_tvalid,
	output logic        ctrl_m_axis_tlast,

	output logic        tbl_wr_en,
	output tbl_index_t  tbl_wr_index,
	output act_entry_t  tbl_wr_entry
);

	localparam int ENTRY_BYTES = `PARSER_ENTRY_WIDTH / 8;

	ctrl_state_e state;
	logic [2:0]  mod_id;
	logic [15:0] ctrl_flag;
	logic        is_header;
	act_entry_t  entry_swapped;

	// header fields, low 3 bits of the module id byte
	assign mod_id = ctrl_s_axis_tdata[`PARSER_MODID_LSB +: 3];
	assign ctrl_flag = ctrl_s_axis_tdata[`PARSER_FLAG_LSB +: 16];
	assign is_header = ctrl_s_axis_tvalid
		&& (mod_id == `PARSER_MOD_ID)
		&& (ctrl_flag == `PARSER_CTRL_FLAG);

	// first bytes of the beat, byte 0 ends up most significant
	always_comb begin
		for (int i = 0; i < ENTRY_BYTES; i++) begin
			entry_swapped[(ENTRY_BYTES-1-i)*8 +: 8] = ctrl_s_axis_tdata[i*8 +: 8];
		end
	end

	// ========================================================================
	// write sequence
	// ========================================================================
	always_ff @(posedge axis_clk or negedge aresetn) begin
		if (!aresetn) begin
			state <= CTRL_IDLE;
			tbl_wr_en <= 1'b0;
			tbl_wr_index <= '0;
			ctrl_m_axis_tvalid <= 1'b0;
		end else begin
			tbl_wr_en <= 1'b0;
			ctrl_m_axis_tvalid <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					if (is_header) begin
						tbl_wr_index <= ctrl_s_axis_tdata[`PARSER_INDEX_LSB +: $bits(tbl_index_t)];
						state <= CTRL_WR_FIRST;
					end else begin
						// not for us, pass on
						ctrl_m_axis_tvalid <= ctrl_s_axis_tvalid;
					end
				end
				CTRL_WR_FIRST: begin
					if (ctrl_s_axis_tvalid) begin
						tbl_wr_en <= 1'b1;
						state <= ctrl_s_axis_tlast ? CTRL_IDLE : CTRL_WR_MORE;
					end
				end
				CTRL_WR_MORE: begin
					if (ctrl_s_axis_tvalid) begin
						tbl_wr_en <= 1'b1;
						tbl_wr_index <= tbl_wr_index + 1'b1;
						if (ctrl_s_axis_tlast) begin
							state <= CTRL_IDLE;
						end
					end
				end
				default: begin
					state <= CTRL_IDLE;
				end
			endcase
		end
	end

	// forwarded beat and entry payload
	always_ff @(posedge axis_clk) begin
		if (state == CTRL_IDLE) begin
			ctrl_m_axis_tdata <= ctrl_s_axis_tdata;
			ctrl_m_axis_tuser <= ctrl_s_axis_tuser;
			ctrl_m_axis_tkeep <= ctrl_s_axis_tkeep;
			ctrl_m_axis_tlast <= ctrl_s_axis_tlast;
		end
		if (state != CTRL_IDLE && ctrl_s_axis_tvalid) begin
			tbl_wr_entry <= entry_swapped;
		end
	end

endmodule

// File: test/parser_chk.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module parser_chk
	import parser_pkg::*;
(
	input logic                          axis_clk,
	input logic                          aresetn,
	input logic [`PARSER_NUM_QUEUES-1:0] m_axis_tvalid,
	input logic                          act_valid,
	input axis_data_t                    ctrl_s_axis_tdata,
	input logic                          ctrl_s_axis_tvalid,
	input logic                          ctrl_m_axis_tvalid
);

	int   fail_count;
	logic header_beat;

	// beat matching the write header pattern
	assign header_beat = ctrl_s_axis_tvalid
		&& (ctrl_s_axis_tdata[`PARSER_MODID_LSB +: 3] == `PARSER_MOD_ID)
		&& (ctrl_s_axis_tdata[`PARSER_FLAG_LSB +: 16] == `PARSER_CTRL_FLAG);

	// ========================================================================
	// protocol properties
	// ========================================================================
	queue_valid_onehot: assert property (
		@(posedge axis_clk) disable iff (!aresetn) $onehot0(m_axis_tvalid)
	) else begin
		$error("more than one queue valid at once");
		fail_count++;
	end

	act_valid_single: assert property (
		@(posedge axis_clk) disable iff (!aresetn) act_valid |=> !act_valid
	) else begin
		$error("act_valid high for two cycles");
		fail_count++;
	end

	header_not_forwarded: assert property (
		@(posedge axis_clk) disable iff (!aresetn) header_beat |=> !ctrl_m_axis_tvalid
	) else begin
		$error("write header forwarded on the control output");
		fail_count++;
	end

endmodule

bind parser_top parser_chk parser_chk_inst (
	.axis_clk           (axis_clk),
	.aresetn            (aresetn),
	.m_axis_tvalid      (m_axis_tvalid),
	.act_valid          (act_valid),
	.ctrl_s_axis_tdata  (ctrl_s_axis_tdata),
	.ctrl_s_axis_tvalid (ctrl_s_axis_tvalid),
	.ctrl_m_axis_tvalid (ctrl_m_axis_tvalid)
);

// File: test/parser_tb.sv
`timescale 1ns/100ps
`include "parser_settings.svh"

module parser_tb
	import parser_pkg::*;
();

	logic                          axis_clk;
	logic                          aresetn;
	axis_data_t                    s_axis_tdata;
	axis_tuser_t                   s_axis_tuser;
	axis_tkeep_t                   s_axis_tkeep;
	logic                          s_axis_tvalid;
	logic                          s_axis_tlast;
	logic                          s_axis_tready;
	axis_data_t                    m_axis_tdata;
	axis_tuser_t                   m_axis_tuser;
	axis_tkeep_t                   m_axis_tkeep;
	logic                          m_axis_tlast;
	logic [`PARSER_NUM_QUEUES-1:0] m_axis_tvalid;
	logic [`PARSER_NUM_QUEUES-1:0] m_axis_tready;
	vlan_id_t                      s_vlan_id;
	logic                          s_vlan_id_valid;
	act_entry_t                    act_entry;
	logic                          act_valid;
	axis_data_t                    ctrl_s_axis_tdata;
	axis_tuser_t                   ctrl_s_axis_tuser;
	axis_tkeep_t                   ctrl_s_axis_tkeep;
	logic                          ctrl_s_axis_tvalid;
	logic                          ctrl_s_axis_tlast;
	axis_data_t                    ctrl_m_axis_tdata;
	axis_tuser_t                   ctrl_m_axis_tuser;
	axis_tkeep_t                   ctrl_m_axis_tkeep;
	logic                          ctrl_m_axis_tvalid;
	logic                          ctrl_m_axis_tlast;

	// reference model state
	act_entry_t  model_tbl [`PARSER_TBL_DEPTH];
	queue_sel_t  exp_queue;
	logic [705:0] fwd_q [$];

	parser_top parser_top_inst (.*);

	initial begin
		axis_clk = 1'b0;
		forever #10 axis_clk = ~axis_clk;
	end

	// ========================================================================
	// helpers
	// ========================================================================
	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	function automatic axis_data_t rand_data();
		axis_data_t d;
		for (int i = 0; i < `PARSER_DATA_WIDTH / 32; i++) begin
			d[i*32 +: 32] = $urandom;
		end
		return d;
	endfunction

	// entry = leading bytes of the beat, byte 0 most significant
	function automatic act_entry_t entry_of(input axis_data_t d);
		act_entry_t e;
		for (int b = 0; b < `PARSER_ENTRY_WIDTH / 8; b++) begin
			e[`PARSER_ENTRY_WIDTH - 8 - 8*b +: 8] = d[8*b +: 8];
		end
		return e;
	endfunction

	// one control beat, output compared one cycle later
	task automatic ctrl_beat(input axis_data_t data, input logic valid, input logic last,
		input logic fwd);
		logic [705:0] exp_beat;
		ctrl_s_axis_tdata = data;
		ctrl_s_axis_tuser = axis_tuser_t'(rand_data());
		ctrl_s_axis_tkeep = {$urandom, $urandom};
		ctrl_s_axis_tvalid = valid;
		ctrl_s_axis_tlast = last;
		if (fwd) begin
			fwd_q.push_back({valid, last, ctrl_s_axis_tkeep, ctrl_s_axis_tuser, data});
		end
		@(negedge axis_clk);
		if (fwd) begin
			exp_beat = fwd_q.pop_front();
			check_value("ctrl_m_axis_tvalid", ctrl_m_axis_tvalid, exp_beat[705]);
			check_value("ctrl_m_axis_tlast", ctrl_m_axis_tlast, exp_beat[704]);
			check_value("ctrl_m_axis_tkeep", ctrl_m_axis_tkeep, exp_beat[640 +: 64]);
			check_value("ctrl_m_axis_tuser", ctrl_m_axis_tuser, exp_beat[512 +: 128]);
			check_value("ctrl_m_axis_tdata", ctrl_m_axis_tdata, exp_beat[511:0]);
		end else begin
			check_value("ctrl_m_axis_tvalid", ctrl_m_axis_tvalid, 1'b0);
		end
	endtask

	// wrong module id or wrong flag, must be forwarded
	task automatic wrong_beat();
		axis_data_t d;
		d = rand_data();
		if ($urandom_range(1) == 1) begin
			d[`PARSER_MODID_LSB +: 3] = $urandom_range(7, 1);
		end else begin
			d[`PARSER_FLAG_LSB +: 16] = `PARSER_CTRL_FLAG ^ $urandom_range(16'hffff, 1);
		end
		ctrl_beat(d, $urandom_range(3) != 0, $urandom_range(1), 1'b1);
	endtask

	task automatic write_burst(input tbl_index_t index, input int len);
		axis_data_t d;
		d = rand_data();
		d[`PARSER_MODID_LSB +: 3] = `PARSER_MOD_ID;
		d[`PARSER_FLAG_LSB +: 16] = `PARSER_CTRL_FLAG;
		d[`PARSER_INDEX_LSB +: 8] = index;
		ctrl_beat(d, 1'b1, 1'b0, 1'b0);
		for (int k = 0; k < len; k++) begin
			d = rand_data();
			model_tbl[(index + k) % `PARSER_TBL_DEPTH] = entry_of(d);
			ctrl_beat(d, 1'b1, k == len - 1, 1'b0);
		end
	endtask

	// packet beat held until the dispatcher takes it
	task automatic send_beat(input logic last);
		int   tries;
		logic accepted;
		logic [`PARSER_NUM_QUEUES-1:0] exp_valid;
		s_axis_tdata = rand_data();
		s_axis_tuser = axis_tuser_t'(rand_data());
		s_axis_tkeep = {$urandom, $urandom};
		s_axis_tvalid = 1'b1;
		s_axis_tlast = last;
		tries = 0;
		accepted = 1'b0;
		while (!accepted) begin
			if (tries == 100) begin
				stop_with_error("timeout: a packet beat was never accepted");
			end
			m_axis_tready = ($urandom_range(3) == 0) ? 4'hf : 4'($urandom);
			#5;
			exp_valid = m_axis_tready[exp_queue] ? 4'b1 << exp_queue : 4'b0;
			check_value("m_axis_tvalid", m_axis_tvalid, exp_valid);
			check_value("s_axis_tready", s_axis_tready, &m_axis_tready);
			check_value("m_axis_tdata", m_axis_tdata, s_axis_tdata);
			check_value("m_axis_tuser", m_axis_tuser, s_axis_tuser);
			check_value("m_axis_tkeep", m_axis_tkeep, s_axis_tkeep);
			check_value("m_axis_tlast", m_axis_tlast, last);
			accepted = s_axis_tready;
			tries++;
			@(negedge axis_clk);
		end
		if (last) begin
			exp_queue = exp_queue + 1'b1;
		end
	endtask

	// request edge is t, act_valid expected at the fourth falling edge
	task automatic lookup(input vlan_id_t vlan, input logic with_tlast);
		int cycles;
		s_vlan_id = vlan;
		s_vlan_id_valid = 1'b1;
		if (with_tlast) begin
			s_axis_tdata = rand_data();
			s_axis_tvalid = 1'b1;
			s_axis_tlast = 1'b1;
			exp_queue = exp_queue + 1'b1;
		end
		@(negedge axis_clk);
		s_vlan_id_valid = 1'b0;
		s_axis_tvalid = 1'b0;
		check_value("s_axis_tready", s_axis_tready, !with_tlast);
		cycles = 1;
		while (!act_valid) begin
			if (cycles > 10) begin
				stop_with_error("timeout: act_valid never rose after a lookup request");
			end
			@(negedge axis_clk);
			cycles++;
			if (cycles == 2) begin
				check_value("s_axis_tready", s_axis_tready, 1'b1);
			end
		end
		check_value("act_valid latency", cycles, 4);
		check_value("act_entry", act_entry, model_tbl[vlan[8:4]]);
	endtask

	// assertion failures in the bound checker end the run too
	always @(negedge axis_clk) begin
		if (parser_top_inst.parser_chk_inst.fail_count != 0) begin
			stop_with_error("an assertion in the bound checker failed");
		end
	end

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		int n;
		void'($urandom(32'h94c0));
		aresetn = 1'b0;
		s_axis_tdata = '0;
		s_axis_tuser = '0;
		s_axis_tkeep = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		m_axis_tready = '1;
		s_vlan_id = '0;
		s_vlan_id_valid = 1'b0;
		ctrl_s_axis_tdata = '0;
		ctrl_s_axis_tuser = '0;
		ctrl_s_axis_tkeep = '0;
		ctrl_s_axis_tvalid = 1'b0;
		ctrl_s_axis_tlast = 1'b0;
		exp_queue = '0;
		repeat (3) @(negedge axis_clk);
		aresetn = 1'b1;
		#5;
		check_value("s_axis_tready", s_axis_tready, 1'b1);
		check_value("act_valid", act_valid, 1'b0);
		check_value("ctrl_m_axis_tvalid", ctrl_m_axis_tvalid, 1'b0);
		check_value("m_axis_tvalid", m_axis_tvalid, '0);
		@(negedge axis_clk);

		// packets of 1 to 4 beats under random back-pressure
		for (int p = 0; p < 24; p++) begin
			n = $urandom_range(4, 1);
			for (int b = 0; b < n; b++) begin
				send_beat(b == n - 1);
			end
			s_axis_tvalid = 1'b0;
		end
		m_axis_tready = '1;

		// fill the whole table, then random bursts between foreign beats
		write_burst(8'd0, `PARSER_TBL_DEPTH);
		for (int w = 0; w < 12; w++) begin
			wrong_beat();
			write_burst(tbl_index_t'($urandom), $urandom_range(4, 1));
			wrong_beat();
		end
		ctrl_beat('0, 1'b0, 1'b0, 1'b1);

		for (int l = 0; l < 16; l++) begin
			lookup(vlan_id_t'($urandom), 1'b0);
		end
		lookup(vlan_id_t'($urandom), 1'b1);
		send_beat(1'b1);
		s_axis_tvalid = 1'b0;
		@(negedge axis_clk);

		if (parser_top_inst.parser_chk_inst.fail_count != 0) begin
			stop_with_error("an assertion in the bound checker failed");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule
